/* src.f */
+incdir+src
src/audio_pkg.sv
src/ctl_pkg.sv
src/sample_if.sv
src/spdif_dai.sv
src/sample_ringbuf.sv
src/mixer.sv
src/dac_drv.sv
src/dmix_top.sv
sim/tb_spdif_enc.sv
sim/tb_dmix.sv

/* sim/tb_dmix.sv */
`timescale 1ns/1ps
`include "dmix_defines.svh"

module tb_dmix;
    logic        clk245760;
    logic        rst;
    logic        start;
    logic [15:0] gain_a;
    logic [15:0] gain_b;
    logic        spdif_a;
    logic        spdif_b;
    logic        busy_a;
    logic        busy_b;
    logic        dac_sck;
    logic        dac_bck;
    logic        dac_lrck;
    logic        dac_data;
    logic        led;

    logic [31:0] lfsr = 32'ha55c;
    int          cyc = 0;
    int          cyc_limit = 4096;
    int          err_cnt = 0;
    string       test_name = "init";
    logic [23:0] exp_w [$];
    logic        exp_c [$];
    logic        seen_nz;
    int          lead_zero;

    // capture and framing state
    logic        lr_q, bck_q, sck_q, data_q;
    logic        lr_ok, bck_ok, sck_ok;
    int          lr_last, bck_last, sck_last;
    int          bitpos;
    logic [23:0] word;

    tb_spdif_enc enc_a (.clk245760(clk245760), .start_i(start), .line_o(spdif_a), .busy_o(busy_a));
    tb_spdif_enc enc_b (.clk245760(clk245760), .start_i(start), .line_o(spdif_b), .busy_o(busy_b));

    dmix_top UUT (
        .clk245760  (clk245760),
        .rst        (rst),
        .spdif_a_i  (spdif_a),
        .spdif_b_i  (spdif_b),
        .gain_a_i   (gain_a),
        .gain_b_i   (gain_b),
        .dac_sck_o  (dac_sck),
        .dac_bck_o  (dac_bck),
        .dac_lrck_o (dac_lrck),
        .dac_data_o (dac_data),
        .led_o      (led)
    );

    initial begin
        clk245760 = 1'b0;
        forever #2 clk245760 = ~clk245760;
    end

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (exp === act) else begin
            err_cnt++;
            $display("FAIL %s expected %h actual %h", name, exp, act);
            $display("Finished with errors");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string msg);
        err_cnt++;
        $display("ERROR: %s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    // galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    // random sample within a quarter of full scale
    function automatic logic [23:0] rand_quarter();
        logic [31:0] v;
        v = rand_bits(22);
        return {{2{v[21]}}, v[21:0]};
    endfunction

    // gain products summed, 8.8 fraction dropped, clipped to 24 bits
    function automatic logic [23:0] expect_mix(input logic signed [23:0] a,
                                               input logic signed [23:0] b,
                                               input logic [15:0] ga,
                                               input logic [15:0] gb);
        longint s;
        s = (longint'(a) * longint'(ga) + longint'(b) * longint'(gb)) >>> 8;
        if (s > 64'sd8388607) begin
            return 24'h7fffff;
        end else if (s < -64'sd8388608) begin
            return 24'h800000;
        end
        return s[23:0];
    endfunction

    // compare one I2S word against the expected order
    task automatic take_word(input logic [23:0] w, input logic tag);
        if (exp_w.size() == 0) begin
            return;
        end
        if (!seen_nz && w == 24'd0) begin
            // silence while buffers are still empty
            lead_zero++;
            if (lead_zero > 16) begin
                abort_run({test_name, ": no audio reached the DAC"});
            end
            return;
        end
        // first audio word is the first frame written after lock
        seen_nz = 1'b1;
        check_value({test_name, " word"}, exp_w[0], w);
        check_value({test_name, " lrck"}, exp_c[0], tag);
        void'(exp_w.pop_front());
        void'(exp_c.pop_front());
    endtask

    always @(posedge clk245760) begin
        cyc = cyc + 1;
        if (cyc > cyc_limit) begin
            abort_run({test_name, ": timed out waiting for I2S words"});
        end
    end

    // I2S capture and framing, sampled mid cycle
    always @(negedge clk245760) begin
        if (rst) begin
            lr_q   = 1'b0;
            bck_q  = 1'b0;
            sck_q  = 1'b0;
            data_q = 1'b0;
            lr_ok  = 1'b0;
            bck_ok = 1'b0;
            sck_ok = 1'b0;
            bitpos = 99;
            word   = '0;
        end else begin
            if (dac_sck && !sck_q) begin
                if (sck_ok) check_value("sck period", 2, cyc - sck_last);
                sck_ok   = 1'b1;
                sck_last = cyc;
            end
            if (dac_data != data_q) begin
                check_value("data edge bck", 0, dac_bck);
            end
            if (dac_lrck != lr_q) begin
                if (lr_ok) check_value("lrck half period", 256, cyc - lr_last);
                lr_ok   = 1'b1;
                lr_last = cyc;
                bitpos  = 0;
                word    = '0;
            end else if (dac_bck && !bck_q) begin
                if (bck_ok) check_value("bck period", 8, cyc - bck_last);
                bck_ok   = 1'b1;
                bck_last = cyc;
                // MSB sits in the second bck slot
                if (bitpos >= 1 && bitpos <= 24) begin
                    word = {word[22:0], dac_data};
                end
                if (bitpos == 24) begin
                    take_word(word, dac_lrck);
                end
                if (bitpos < 99) begin
                    bitpos++;
                end
            end
            lr_q   = dac_lrck;
            bck_q  = dac_bck;
            sck_q  = dac_sck;
            data_q = dac_data;
        end
    end

    task automatic run_stream(input string name, input int frames, input logic [15:0] ga,
                              input logic [15:0] gb, input bit sat);
        logic [23:0] al, ar, bl, br;
        int          f;
        test_name = name;
        cyc_limit = cyc + (frames + 6) * 512 + 4096;
        exp_w.delete();
        exp_c.delete();
        enc_a.clear_pairs();
        enc_b.clear_pairs();
        seen_nz   = 1'b0;
        lead_zero = 0;
        gain_a    = ga;
        gain_b    = gb;
        rst       = 1'b1;
        repeat (2) @(negedge clk245760);
        rst = 1'b0;
        // idle inputs, no lock
        repeat (2 * 512) begin
            @(negedge clk245760);
            check_value({name, " idle lock"}, 0, led);
        end
        for (f = 0; f < frames; f++) begin
            al = sat ? 24'h600000 : rand_quarter();
            ar = sat ? 24'ha00000 : rand_quarter();
            bl = rand_quarter();
            br = rand_quarter();
            enc_a.add_pair(al, ar);
            enc_b.add_pair(bl, br);
            // first frame feeds lock, last right word has no closing edge
            if (f >= 1 && f <= frames - 2) begin
                exp_w.push_back(expect_mix(al, bl, ga, gb));
                exp_c.push_back(1'b0);
                exp_w.push_back(expect_mix(ar, br, ga, gb));
                exp_c.push_back(1'b1);
            end
        end
        start = 1'b1;
        @(negedge clk245760);
        start = 1'b0;
        repeat (4 * 512 - 1) @(negedge clk245760);
        check_value({name, " lock"}, 1, led);
        while (exp_w.size() > 0) @(negedge clk245760);
        while (busy_a || busy_b) @(negedge clk245760);
    endtask

    initial begin
        rst    = 1'b1;
        start  = 1'b0;
        gain_a = 16'd256;
        gain_b = 16'd256;
        @(negedge clk245760);
        run_stream("mix", 12, 16'd256, 16'd256, 1'b0);
        run_stream("saturate", 8, 16'd512, 16'd0, 1'b1);
        run_stream("half gain", 8, 16'd128, 16'd0, 1'b0);
        if (err_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end
endmodule

/* sim/tb_spdif_enc.sv */
`timescale 1ns/1ps
`include "dmix_defines.svh"

module tb_spdif_enc (
    input  logic clk245760,
    input  logic start_i,
    output logic line_o,
    output logic busy_o
);
    // preamble half cells as sent after a low line
    localparam logic [7:0] PRE_B = 8'b11101000;
    localparam logic [7:0] PRE_M = 8'b11100010;
    localparam logic [7:0] PRE_W = 8'b11100100;

    logic [23:0] q_l [$];
    logic [23:0] q_r [$];

    task automatic add_pair(input logic [23:0] l, input logic [23:0] r);
        q_l.push_back(l);
        q_r.push_back(r);
    endtask

    task automatic clear_pairs();
        q_l.delete();
        q_r.delete();
    endtask

    // one half cell, entered on a falling edge
    task automatic hold_half(input logic lvl);
        line_o = lvl;
        repeat (`HALF_CELL) @(negedge clk245760);
    endtask

    task automatic send_subframe(input logic [7:0] pre, input logic [23:0] smp);
        logic [27:0] slots;
        logic        prev;
        int          i;
        // audio LSB first, then V U C as zero, then even parity
        slots = {^smp, 3'b000, smp};
        prev  = line_o;
        // pattern flips with the line level it starts from
        for (i = 7; i >= 0; i--) begin
            hold_half(pre[i] ^ prev);
        end
        // every slot starts with a transition, a one adds one mid slot
        for (i = 0; i < 28; i++) begin
            hold_half(~line_o);
            if (slots[i]) begin
                hold_half(~line_o);
            end else begin
                hold_half(line_o);
            end
        end
    endtask

    task automatic send_all();
        int frame;
        frame = 0;
        while (q_l.size() > 0) begin
            // block start every 192 frames
            send_subframe((frame % 192 == 0) ? PRE_B : PRE_M, q_l.pop_front());
            send_subframe(PRE_W, q_r.pop_front());
            frame++;
        end
    endtask

    initial begin
        line_o = 1'b0;
        busy_o = 1'b0;
        forever begin
            @(posedge clk245760);
            if (start_i) begin
                busy_o = 1'b1;
                @(negedge clk245760);
                send_all();
                busy_o = 1'b0;
            end
        end
    end
endmodule

/* src/dmix_top.sv */
`timescale 1ns/1ps
`include "dmix_defines.svh"

module dmix_top (
    input  logic               clk245760,
    input  logic               rst,
    input  logic               spdif_a_i,
    input  logic               spdif_b_i,
    input  logic [`GAIN_W-1:0] gain_a_i,
    input  logic [`GAIN_W-1:0] gain_b_i,
    output logic               dac_sck_o,
    output logic               dac_bck_o,
    output logic               dac_lrck_o,
    output logic               dac_data_o,
    output logic               led_o
);
    localparam int RC_W = $clog2(`RST_DELAY + 1);

    logic [RC_W-1:0]    rst_cnt;
    logic               rst_dp;
    audio_pkg::sample_t smp_a;
    audio_pkg::sample_t smp_b;
    logic               stb_a;
    logic               stb_b;
    logic               chan_a;
    logic               chan_b;
    logic               lock_a;
    logic               lock_b;

    // one link per buffer lane, one into the DAC driver
    sample_if lnk_al ();
    sample_if lnk_ar ();
    sample_if lnk_bl ();
    sample_if lnk_br ();
    sample_if lnk_mix ();

    // datapath held in reset for RST_DELAY clocks after rst falls
    always_ff @(posedge clk245760) begin
        if (rst) begin
            rst_cnt <= '0;
            rst_dp  <= 1'b1;
        end else if (rst_cnt != RC_W'(`RST_DELAY)) begin
            rst_cnt <= rst_cnt + 1'b1;
        end else begin
            rst_dp <= 1'b0;
        end
    end

    // input a
    spdif_dai dai_a (
        .clk245760 (clk245760),
        .rst       (rst_dp),
        .signal_i  (spdif_a_i),
        .sample_o  (smp_a),
        .stb_o     (stb_a),
        .chan_o    (chan_a),
        .locked_o  (lock_a)
    );

    // chan 1 is left
    sample_ringbuf rb_al (
        .clk245760 (clk245760),
        .rst       (rst_dp),
        .we_i      (stb_a & chan_a),
        .data_i    (smp_a),
        .rd        (lnk_al.producer)
    );

    sample_ringbuf rb_ar (
        .clk245760 (clk245760),
        .rst       (rst_dp),
        .we_i      (stb_a & ~chan_a),
        .data_i    (smp_a),
        .rd        (lnk_ar.producer)
    );

    // input b
    spdif_dai dai_b (
        .clk245760 (clk245760),
        .rst       (rst_dp),
        .signal_i  (spdif_b_i),
        .sample_o  (smp_b),
        .stb_o     (stb_b),
        .chan_o    (chan_b),
        .locked_o  (lock_b)
    );

    sample_ringbuf rb_bl (
        .clk245760 (clk245760),
        .rst       (rst_dp),
        .we_i      (stb_b & chan_b),
        .data_i    (smp_b),
        .rd        (lnk_bl.producer)
    );

    sample_ringbuf rb_br (
        .clk245760 (clk245760),
        .rst       (rst_dp),
        .we_i      (stb_b & ~chan_b),
        .data_i    (smp_b),
        .rd        (lnk_br.producer)
    );

    mixer mix (
        .clk245760 (clk245760),
        .rst       (rst_dp),
        .gain_a_i  (gain_a_i),
        .gain_b_i  (gain_b_i),
        .src_al    (lnk_al.consumer),
        .src_ar    (lnk_ar.consumer),
        .src_bl    (lnk_bl.consumer),
        .src_br    (lnk_br.consumer),
        .dst       (lnk_mix.producer)
    );

    dac_drv dac (
        .clk245760 (clk245760),
        .rst       (rst_dp),
        .src       (lnk_mix.consumer),
        .sck_o     (dac_sck_o),
        .bck_o     (dac_bck_o),
        .lrck_o    (dac_lrck_o),
        .data_o    (dac_data_o)
    );

    // lit only with both inputs locked
    assign led_o = lock_a & lock_b;
endmodule

/* src/dac_drv.sv */
`timescale 1ns/1ps
`include "dmix_defines.svh"

module dac_drv (
    input  logic       clk245760,
    input  logic       rst,
    sample_if.consumer src,
    output logic       sck_o,
    output logic       bck_o,
    output logic       lrck_o,
    output logic       data_o
);
    // positions within a 256 clock half frame
    // pop 8 clocks before the lrck edge
    localparam logic [7:0] POP_AT = 8'd247;
    // MSB goes out one bck after the lrck edge
    localparam logic [7:0] LOAD_AT = 8'd7;
    // last audio bit has left, only padding follows
    localparam logic [7:0] DONE_AT = 8'(8 * (`SAMPLE_W + 1) - 1);

    ctl_pkg::dac_state_t state;
    logic [8:0]          fc;
    logic                bck_fall;
    audio_pkg::sample_t  hold;
    audio_pkg::sample_t  sr;

    // clock divider taps
    assign sck_o  = fc[0];
    assign bck_o  = fc[2];
    // low half is left
    assign lrck_o = fc[8];
    assign data_o = sr[`SAMPLE_W-1];

    // next edge takes bck low
    assign bck_fall = (fc[2:0] == 3'b111);

    always_ff @(posedge clk245760) begin
        if (rst) begin
            fc <= '0;
        end else begin
            fc <= fc + 9'd1;
        end
    end

    always_ff @(posedge clk245760) begin
        src.pop_l <= 1'b0;
        src.pop_r <= 1'b0;
        if (rst) begin
            state <= ctl_pkg::DAC_IDLE;
            sr    <= '0;
        end else begin
            case (state)
                ctl_pkg::DAC_IDLE: begin
                    if (fc[7:0] == POP_AT) begin
                        // fc[8] still names the half now playing
                        src.pop_l <= fc[8];
                        src.pop_r <= ~fc[8];
                        state     <= ctl_pkg::DAC_FETCH;
                    end
                end
                ctl_pkg::DAC_FETCH: begin
                    if (src.ack_l || src.ack_r) begin
                        state <= ctl_pkg::DAC_SHIFT;
                    end
                end
                ctl_pkg::DAC_SHIFT: begin
                    if (fc[7:0] == DONE_AT) begin
                        state <= ctl_pkg::DAC_IDLE;
                    end
                end
                default: state <= ctl_pkg::DAC_IDLE;
            endcase

            // data moves with bck falling, zeros pad the rest of the word
            if (bck_fall) begin
                if (state == ctl_pkg::DAC_SHIFT && fc[7:0] == LOAD_AT) begin
                    sr <= hold;
                end else begin
                    sr <= sr << 1;
                end
            end
        end
    end

    // latch the fetched word on its ack
    always_ff @(posedge clk245760) begin
        if (src.ack_l || src.ack_r) begin
            hold <= src.data;
        end
    end
endmodule

/* src/mixer.sv */
`timescale 1ns/1ps
`include "dmix_defines.svh"

module mixer (
    input  logic             clk245760,
    input  logic             rst,
    input  audio_pkg::gain_t gain_a_i,
    input  audio_pkg::gain_t gain_b_i,
    sample_if.consumer       src_al,
    sample_if.consumer       src_ar,
    sample_if.consumer       src_bl,
    sample_if.consumer       src_br,
    sample_if.producer       dst
);
    // 8.8 gain, so drop the fraction after the sum
    localparam int GAIN_FRAC = `GAIN_W / 2;
    localparam longint SAT_HI = (64'sd1 <<< (`SAMPLE_W - 1)) - 1;
    localparam longint SAT_LO = -SAT_HI - 1;

    audio_pkg::sample_t  smp_a;
    audio_pkg::sample_t  smp_b;
    audio_pkg::mix_acc_t prod_a;
    audio_pkg::mix_acc_t prod_b;
    audio_pkg::mix_acc_t acc_q;
    audio_pkg::mix_acc_t scaled;
    logic                ack_l_q;
    logic                ack_r_q;

    // left pops reach both left lanes, right pops both right lanes
    assign src_al.pop_l = dst.pop_l;
    assign src_bl.pop_l = dst.pop_l;
    assign src_ar.pop_r = dst.pop_r;
    assign src_br.pop_r = dst.pop_r;
    // a lane is never asked for the other channel
    assign src_al.pop_r = 1'b0;
    assign src_bl.pop_r = 1'b0;
    assign src_ar.pop_l = 1'b0;
    assign src_br.pop_l = 1'b0;

    // pick the lane pair that answered this cycle
    assign smp_a = src_al.ack_l ? src_al.data : src_ar.data;
    assign smp_b = src_bl.ack_l ? src_bl.data : src_br.data;

    // sample sign-extends, gain zero-extends
    assign prod_a = audio_pkg::mix_acc_t'(smp_a) * audio_pkg::mix_acc_t'(gain_a_i);
    assign prod_b = audio_pkg::mix_acc_t'(smp_b) * audio_pkg::mix_acc_t'(gain_b_i);

    always_ff @(posedge clk245760) begin
        if (rst) begin
            ack_l_q <= 1'b0;
            ack_r_q <= 1'b0;
        end else begin
            ack_l_q <= src_al.ack_l;
            ack_r_q <= src_ar.ack_r;
        end
    end

    // product sum registered on the source ack
    always_ff @(posedge clk245760) begin
        if (src_al.ack_l || src_ar.ack_r) begin
            acc_q <= prod_a + prod_b;
        end
    end

    // answer lands two cycles after the pop
    assign dst.ack_l = ack_l_q;
    assign dst.ack_r = ack_r_q;

    assign scaled = acc_q >>> GAIN_FRAC;

    // clip to full scale
    always_comb begin
        if (scaled > SAT_HI) begin
            dst.data = {1'b0, {(`SAMPLE_W-1){1'b1}}};
        end else if (scaled < SAT_LO) begin
            dst.data = {1'b1, {(`SAMPLE_W-1){1'b0}}};
        end else begin
            dst.data = scaled[`SAMPLE_W-1:0];
        end
    end
endmodule

/* src/sample_ringbuf.sv */
`timescale 1ns/1ps
`include "dmix_defines.svh"

module sample_ringbuf (
    input  logic               clk245760,
    input  logic               rst,
    input  logic               we_i,
    input  audio_pkg::sample_t data_i,
    sample_if.producer         rd
);
    localparam int DEPTH = 1 << `RING_AW;

    audio_pkg::sample_t   mem [DEPTH];
    audio_pkg::ring_ptr_t wr_ptr;
    audio_pkg::ring_ptr_t rd_ptr;
    logic                 empty;
    logic                 full;
    logic                 pop;
    logic                 push;

    // equal pointers mean nothing stored
    assign empty = (wr_ptr == rd_ptr);
    // same slot with different wrap bits means every slot taken
    assign full = (wr_ptr[`RING_AW-1:0] == rd_ptr[`RING_AW-1:0]) &&
                  (wr_ptr[`RING_AW] != rd_ptr[`RING_AW]);

    // new samples are dropped when full
    assign push = we_i && !full;
    // one lane serves whichever channel its consumer asks for
    assign pop = rd.pop_l | rd.pop_r;

    always_ff @(posedge clk245760) begin
        if (push) begin
            mem[wr_ptr[`RING_AW-1:0]] <= data_i;
        end
    end

    always_ff @(posedge clk245760) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            rd.ack_l <= 1'b0;
            rd.ack_r <= 1'b0;
        end else begin
            // ack exactly one cycle after pop
            rd.ack_l <= rd.pop_l;
            rd.ack_r <= rd.pop_r;
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // underrun leaves the read side where it is
            if (pop && !empty) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // head sample, zero on underrun
    always_ff @(posedge clk245760) begin
        if (pop) begin
            rd.data <= empty ? '0 : mem[rd_ptr[`RING_AW-1:0]];
        end
    end
endmodule

/* src/spdif_dai.sv */
`timescale 1ns/1ps
`include "dmix_defines.svh"

module spdif_dai (
    input  logic               clk245760,
    input  logic               rst,
    input  logic               signal_i,
    output audio_pkg::sample_t sample_o,
    output logic               stb_o,
    output logic               chan_o,
    output logic               locked_o
);
    // legal run window in clocks
    localparam int RUN_MIN = `HALF_CELL - 1;
    localparam int RUN_MAX = 3 * `HALF_CELL + 1;
    // thresholds between 1, 2 and 3 half cell runs
    localparam int CUT_12 = `HALF_CELL + `HALF_CELL / 2;
    localparam int CUT_23 = 2 * `HALF_CELL + `HALF_CELL / 2;
    // 24 audio slots then V, U, C, P
    localparam logic [4:0] LAST_SLOT = 5'd27;

    ctl_pkg::dai_state_t state;
    logic [2:0]          sync;
    logic                trans;
    logic [4:0]          run_cnt;
    logic [1:0]          run_hc;
    logic                run_bad;
    logic [3:0]          pre_hc;
    logic [3:0]          pre_sum;
    logic [4:0]          slot;
    logic                half;
    logic                good_q;
    logic                bit_done;
    logic [27:0]         sub_sr;
    logic [27:0]         sub_nx;

    // any transition of the synchronised line ends a run
    assign trans = sync[2] ^ sync[1];

    // run length in half cells
    assign run_hc = (run_cnt < CUT_12) ? 2'd1 : (run_cnt < CUT_23) ? 2'd2 : 2'd3;

    // too long is caught while still running, so an idle line drops lock
    assign run_bad = (run_cnt > RUN_MAX) || (trans && (run_cnt < RUN_MIN));

    assign pre_sum = pre_hc + {2'b00, run_hc};

    // a slot ends on one long run or on the second short run
    assign bit_done = trans && (state == ctl_pkg::DAI_BITS) &&
                      ((run_hc == 2'd2 && !half) || (run_hc == 2'd1 && half));

    // slots enter at the top, so the first one ends up in bit 0
    assign sub_nx = {(run_hc == 2'd1), sub_sr[27:1]};

    always_ff @(posedge clk245760) begin
        stb_o <= 1'b0;
        if (rst) begin
            sync     <= '0;
            run_cnt  <= '0;
            state    <= ctl_pkg::DAI_HUNT;
            pre_hc   <= '0;
            slot     <= '0;
            half     <= 1'b0;
            good_q   <= 1'b0;
            locked_o <= 1'b0;
            chan_o   <= 1'b0;
        end else begin
            sync <= {sync[1:0], signal_i};

            // clocks since last transition, saturating
            if (trans) begin
                run_cnt <= 5'd1;
            end else if (run_cnt != '1) begin
                run_cnt <= run_cnt + 5'd1;
            end

            if (run_bad) begin
                state    <= ctl_pkg::DAI_HUNT;
                good_q   <= 1'b0;
                locked_o <= 1'b0;
            end else if (trans) begin
                case (state)
                    ctl_pkg::DAI_HUNT: begin
                        // only a preamble has a 3 half cell run
                        if (run_hc == 2'd3) begin
                            state  <= ctl_pkg::DAI_PRE;
                            pre_hc <= 4'd3;
                        end
                    end
                    ctl_pkg::DAI_PRE: begin
                        // second run is 1 for B, 3 for M, 2 for W
                        if (pre_hc == 4'd3) begin
                            chan_o <= (run_hc != 2'd2);
                        end
                        pre_hc <= pre_sum;
                        // every preamble spans 8 half cells
                        if (pre_sum == 4'd8) begin
                            state <= ctl_pkg::DAI_BITS;
                            slot  <= '0;
                            half  <= 1'b0;
                        end else if (pre_sum > 4'd8) begin
                            state <= ctl_pkg::DAI_HUNT;
                        end
                    end
                    ctl_pkg::DAI_BITS: begin
                        if (run_hc == 2'd3 || (run_hc == 2'd2 && half)) begin
                            // biphase violation inside the data slots
                            state  <= ctl_pkg::DAI_HUNT;
                            good_q <= 1'b0;
                        end else if (!bit_done) begin
                            half <= 1'b1;
                        end else begin
                            half <= 1'b0;
                            slot <= slot + 5'd1;
                            if (slot == LAST_SLOT) begin
                                state <= ctl_pkg::DAI_HUNT;
                                // even parity over slots 4 to 31
                                if (^sub_nx == 1'b0) begin
                                    good_q <= 1'b1;
                                    if (good_q) begin
                                        locked_o <= 1'b1;
                                    end
                                    if (locked_o) begin
                                        stb_o <= 1'b1;
                                    end
                                end else begin
                                    good_q <= 1'b0;
                                end
                            end
                        end
                    end
                    default: state <= ctl_pkg::DAI_HUNT;
                endcase
            end
        end
    end

    // subframe shifter and sample hold
    always_ff @(posedge clk245760) begin
        if (bit_done) begin
            sub_sr <= sub_nx;
        end
        if (bit_done && slot == LAST_SLOT) begin
            sample_o <= sub_nx[`SAMPLE_W-1:0];
        end
    end
endmodule

/* src/sample_if.sv */
`timescale 1ns/1ps

// pop/ack sample link
// consumer pulses a pop, producer answers one cycle later with ack and data
interface sample_if;
    logic               pop_l;
    logic               pop_r;
    logic               ack_l;
    logic               ack_r;
    audio_pkg::sample_t data;

    modport producer (
        input  pop_l,
        input  pop_r,
        output ack_l,
        output ack_r,
        output data
    );

    modport consumer (
        output pop_l,
        output pop_r,
        input  ack_l,
        input  ack_r,
        input  data
    );
endinterface

/* src/ctl_pkg.sv */
package ctl_pkg;

    // biphase decoder phases
    // hunting for a 3 half cell run, inside a preamble, or in data slots
    typedef enum logic [1:0] {
        DAI_HUNT,
        DAI_PRE,
        DAI_BITS
    } dai_state_t;

    // I2S word fetch sequence
    typedef enum logic [1:0] {
        DAC_IDLE,
        DAC_FETCH,
        DAC_SHIFT
    } dac_state_t;

endpackage

/* src/audio_pkg.sv */
`include "dmix_defines.svh"

package audio_pkg;

    // signed two's complement audio sample
    typedef logic signed [`SAMPLE_W-1:0] sample_t;

    // unsigned 8.8 gain
    typedef logic [`GAIN_W-1:0] gain_t;

    // two sample-by-gain products plus carry into the sum
    typedef logic signed [`SAMPLE_W+`GAIN_W+1:0] mix_acc_t;

    // ring index with wrap bit on top
    typedef logic [`RING_AW:0] ring_ptr_t;

endpackage

/* src/dmix_defines.svh */
`ifndef DMIX_DEFINES_SVH
`define DMIX_DEFINES_SVH

// audio sample width
`define SAMPLE_W 24

// gain width, unsigned 8.8 so 256 is unity
`define GAIN_W 16

// ring address bits, 8 entries per channel
`define RING_AW 3

// clocks per biphase half cell at 48 kHz
`define HALF_CELL 4

// clocks from external reset release to datapath release
`define RST_DELAY 112

`endif
